// ==== sim.f ====
verilog/msoc_pkg.sv
verilog/data_ram.sv
verilog/uart_core.sv
verilog/rx_fifo.sv
verilog/uart_periph.sv
verilog/periph_bus.sv
verilog/msoc_periph_top.sv
dv/msoc_props.sv
dv/tb_msoc.sv

// ==== Makefile ====
# Verilator build and run of the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_msoc
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_msoc.sv ====
// testbench: clock and reset, bus master tasks, reference model, checks and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_msoc;
  import msoc_pkg::*;

  localparam int    RAM_AW      = 10;
  localparam int    FIFO_DEPTH  = 16;
  // 40 chars x 10 bits x divisor 16 = 6400, plus ~400 bus ops, with margin
  localparam int    TIMEOUT_CYC = 20000;
  localparam addr_t TX_ADDR     = {8'h00, SLOT_UART_CTRL, 16'h0, UART_REG_TX, 2'b00};
  localparam addr_t BAUD_ADDR   = {8'h00, SLOT_UART_CTRL, 16'h0, UART_REG_BAUD, 2'b00};
  localparam addr_t RX_ADDR     = {8'h00, SLOT_UART_RX, 20'h0};
  localparam addr_t GPIO_ADDR   = {8'h00, SLOT_GPIO, 20'h0};

  logic     msoc_clk;
  logic     rstn;
  bus_req_t bus_req;
  logic     gnt;
  logic     rvalid;
  word_t    rdata;
  led_t     led;
  dip_t     dip;
  logic     uart_rx;
  logic     uart_tx;
  logic     drv_sel;       // bit driver owns the rx line
  logic     drv_line;
  int       cycles = 0;
  word_t    lcg_state;

  // reference model
  word_t          ram_model [int];   // keyed by word index
  led_t           led_model;
  baud_t          baud_model;
  uart_rx_entry_t rxq_model [$];

  // expected response, armed by bus_read
  string exp_name;
  word_t exp_word;
  word_t exp_mask;
  int    armed_seq   = 0;
  int    checked_seq = 0;

  assign uart_rx = drv_sel ? drv_line : uart_tx;   // loopback unless driver active

  msoc_periph_top #(
    .RAM_AW     (RAM_AW),
    .FIFO_DEPTH (FIFO_DEPTH),
    .BAUD_INIT  (BAUD_RESET)
  ) dut (
    .msoc_clk  (msoc_clk),
    .rstn      (rstn),
    .bus_req_i (bus_req),
    .gnt_o     (gnt),
    .rvalid_o  (rvalid),
    .rdata_o   (rdata),
    .led_o     (led),
    .dip_i     (dip),
    .uart_rx_i (uart_rx),
    .uart_tx_o (uart_tx)
  );

  always #2 msoc_clk = ~msoc_clk;

  ////////////////////////////////////////////////////////////
  // helpers and reference model
  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t ref_read(input addr_t addr);
    uart_status_t st;
    st = '0;
    case (addr[SLOT_MSB:SLOT_LSB])
      SLOT_RAM:       return ram_model[int'(addr[RAM_AW+1:2])];
      SLOT_UART_CTRL: return word_t'(baud_model);
      SLOT_UART_RX:
      begin
        st.not_empty = (rxq_model.size() != 0);
        st.full      = (rxq_model.size() == FIFO_DEPTH);
        if (st.not_empty)
        begin
          st.err  = rxq_model[0].err;
          st.data = rxq_model[0].data;
        end
        return word_t'(st);
      end
      SLOT_GPIO:      return word_t'(dip);
      default:        return '0;
    endcase
  endfunction

  // head entry of an empty fifo is stale
  function automatic word_t ref_mask(input addr_t addr);
    if ((addr[SLOT_MSB:SLOT_LSB] == SLOT_UART_RX) && (rxq_model.size() == 0))
      return 32'hFFFF_FE00;
    return '1;
  endfunction

  task automatic check_eq(input string name, input word_t expected, input word_t actual);
    if (expected !== actual)
    begin
      $display("[FAIL] %s: expected %08h, actual %08h", name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus master
  task automatic bus_access(input logic we, input addr_t addr, input word_t wdata,
                            input be_t be, output word_t rd);
    #0.5;
    bus_req = '{req: 1'b1, we: we, addr: addr, wdata: wdata, be: be};
    #1;
    check_eq("gnt in request cycle", 32'd1, word_t'(gnt));
    check_eq("rvalid low in request cycle", 32'd0, word_t'(rvalid));
    @(posedge msoc_clk);
    #0.5;
    bus_req = '0;
    #1;
    check_eq("rvalid one cycle after request", 32'd1, word_t'(rvalid));
    rd = rdata;
    @(posedge msoc_clk);
  endtask

  task automatic bus_write(input addr_t addr, input word_t wdata, input be_t be);
    word_t rd;
    word_t w;
    int    idx;
    bus_access(1'b1, addr, wdata, be, rd);
    idx = int'(addr[RAM_AW+1:2]);
    case (addr[SLOT_MSB:SLOT_LSB])
      SLOT_RAM:
      begin
        w = ram_model.exists(idx) ? ram_model[idx] : '0;
        for (int b = 0; b < 4; b++)
          if (be[b])
            w[8*b +: 8] = wdata[8*b +: 8];   // byte merge
        ram_model[idx] = w;
      end
      SLOT_UART_CTRL:
        if (addr[3:2] == UART_REG_BAUD)
          baud_model = baud_t'(wdata);
      SLOT_UART_RX:
        if (rxq_model.size() != 0)
          void'(rxq_model.pop_front());
      SLOT_GPIO:
        led_model = led_t'(wdata);
      default:;
    endcase
  endtask

  task automatic bus_read(input string name, input addr_t addr);
    word_t rd;
    exp_name = name;
    exp_word = ref_read(addr);
    exp_mask = ref_mask(addr);
    armed_seq++;
    bus_access(1'b0, addr, '0, '0, rd);
    if (checked_seq != armed_seq)
    begin
      $display("no response compared for read %s", name);
      $display("Simulation finished: FAIL");
      $fatal(1, "response not compared");
    end
  endtask

  // mid-cycle compare of the rvalid word
  always @(negedge msoc_clk)
    if (rvalid && (checked_seq != armed_seq))
    begin
      check_eq(exp_name, exp_word & exp_mask, rdata & exp_mask);
      checked_seq = armed_seq;
    end

  ////////////////////////////////////////////////////////////
  // uart helpers
  task automatic wait_rx_done(input logic check_busy);
    word_t        raw;
    uart_status_t st;
    logic         seen_tx;
    logic         seen_rx;
    seen_tx = 1'b0;
    seen_rx = 1'b0;
    do
    begin
      bus_access(1'b0, RX_ADDR, '0, '0, raw);   // status poll
      st      = uart_status_t'(raw);
      seen_tx = seen_tx | st.transmitting;
      seen_rx = seen_rx | st.receiving;
    end
    while (!st.not_empty || st.receiving || st.transmitting);
    if (check_busy)
    begin
      check_eq("transmitting seen during character", 32'd1, word_t'(seen_tx));
      check_eq("receiving seen during character", 32'd1, word_t'(seen_rx));
    end
  endtask

  task automatic send_byte(input byte_t data);
    bus_write(TX_ADDR, word_t'(data), 4'hF);
    if (rxq_model.size() < FIFO_DEPTH)
      rxq_model.push_back('{err: 1'b0, data: data});   // overflow dropped
    wait_rx_done(1'b1);
  endtask

  task automatic send_bad_frame(input byte_t data);
    logic [9:0] frame;
    frame = {1'b0, data, 1'b0};   // stop bit low
    rxq_model.push_back('{err: 1'b1, data: data});
    #0.5;
    drv_sel = 1'b1;
    for (int i = 0; i < 10; i++)
    begin
      drv_line = frame[i];
      repeat (baud_model) @(posedge msoc_clk);
      #0.5;
    end
    drv_line = 1'b1;
    repeat (2 * baud_model) @(posedge msoc_clk);
    #0.5;
    drv_sel = 1'b0;
    @(posedge msoc_clk);
    wait_rx_done(1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // run limit and bound assertion results
  always @(posedge msoc_clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYC)
    begin
      $display("timeout: test did not finish");
      $display("Simulation finished: FAIL");
      $fatal(1, "cycle limit reached");
    end
    else if ((dut.u_bus.u_bus_props.fail_cnt + dut.u_uart.u_rx_fifo.u_fifo_props.fail_cnt) != 0)
    begin
      $display("a bound bus or fifo assertion failed");
      $display("Simulation finished: FAIL");
      $fatal(1, "assertion failure");
    end
  end

  initial
  begin
    addr_t ram_addrs [$];
    addr_t a;
    word_t w;
    msoc_clk   = 1'b0;
    rstn       = 1'b0;
    bus_req    = '0;
    dip        = '0;
    drv_sel    = 1'b0;
    drv_line   = 1'b1;
    lcg_state  = 32'd84;
    led_model  = '0;
    baud_model = BAUD_RESET;
    repeat (16) @(posedge msoc_clk);
    check_eq("rvalid in reset", 32'd0, word_t'(rvalid));
    check_eq("led_o in reset", 32'd0, word_t'(led));
    check_eq("uart_tx idle in reset", 32'd1, word_t'(uart_tx));
    #0.5;
    rstn = 1'b1;
    @(posedge msoc_clk);
    check_eq("rvalid after reset", 32'd0, word_t'(rvalid));
    bus_read("baud after reset", BAUD_ADDR);

    // ram: full words first, then random byte lanes
    for (int i = 0; i < 16; i++)
    begin
      w = lcg_next();
      a = {8'h00, SLOT_RAM, w[21:4], 2'b00};
      ram_addrs.push_back(a);
      bus_write(a, lcg_next(), 4'hF);
    end
    for (int i = 0; i < 32; i++)
    begin
      w = lcg_next();
      bus_write(ram_addrs[w[27:24]], lcg_next(), w[31:28]);
    end
    foreach (ram_addrs[i])
      bus_read("ram readback", ram_addrs[i]);

    // gpio and unmapped slots
    for (int i = 0; i < 4; i++)
    begin
      w = lcg_next();
      bus_write(GPIO_ADDR, w, 4'hF);
      check_eq("led_o", word_t'(led_model), word_t'(led));
      #0.5;
      dip = dip_t'(w >> 24);
      @(posedge msoc_clk);
      bus_read("dip readback", GPIO_ADDR);
    end
    for (int s = 0; s < 16; s++)
    begin
      w = lcg_next();
      if (!(s inside {1, 2, 3, 7}))
        bus_read("unmapped slot", {8'h00, slot_t'(s), w[19:2], 2'b00});
    end

    // uart loopback at divisor 8
    bus_write(BAUD_ADDR, 32'd8, 4'hF);
    bus_read("baud readback", BAUD_ADDR);
    for (int i = 0; i < 10; i++)
    begin
      send_byte(byte_t'(lcg_next() >> 24));
      bus_read("loopback rx status", RX_ADDR);
      bus_write(RX_ADDR, '0, 4'hF);   // pop
      bus_read("rx status after pop", RX_ADDR);
    end

    // framing error, then overflow
    send_bad_frame(8'hA5);
    bus_read("framing error entry", RX_ADDR);
    bus_write(RX_ADDR, '0, 4'hF);
    for (int i = 0; i < FIFO_DEPTH + 2; i++)
      send_byte(byte_t'(lcg_next() >> 24));
    bus_read("fifo full status", RX_ADDR);
    for (int i = 0; i < FIFO_DEPTH; i++)
    begin
      bus_read("fifo drain order", RX_ADDR);
      bus_write(RX_ADDR, '0, 4'hF);
    end
    bus_read("fifo empty after drain", RX_ADDR);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/msoc_props.sv ====
// bound assertions: bus grant and response timing, rx fifo flag consistency
`timescale 1ns/1ps
`default_nettype none

module msoc_props #(
  parameter bit BUS_CHECKS  = 1'b1,   // grant and response timing
  parameter bit FIFO_CHECKS = 1'b1    // fifo flag pair
)
(
  input wire msoc_clk,
  input wire rstn,
  input wire req_i,
  input wire gnt_i,
  input wire rvalid_i,
  input wire full_i,
  input wire empty_i
);

  int n_timing = 0;
  int n_gnt    = 0;
  int n_flags  = 0;
  int fail_cnt;

  assign fail_cnt = n_timing + n_gnt + n_flags;

  if (BUS_CHECKS)
  begin : g_bus
    // response exactly one cycle after each request, never otherwise
    a_rvalid_timing: assert property (@(posedge msoc_clk) disable iff (!rstn)
                                      rvalid_i == $past(req_i))
      else
      begin
        n_timing = n_timing + 1;
        $error("rvalid does not follow the request by one cycle");
      end

    a_gnt_eq_req: assert property (@(posedge msoc_clk) gnt_i == req_i)
      else
      begin
        n_gnt = n_gnt + 1;
        $error("gnt differs from req");
      end
  end

  if (FIFO_CHECKS)
  begin : g_fifo
    a_full_empty: assert property (@(posedge msoc_clk) disable iff (!rstn)
                                   !(full_i && empty_i))
      else
      begin
        n_flags = n_flags + 1;
        $error("fifo full and empty at once");
      end
  end

endmodule

////////////////////////////////////////////////////////////
// attach to the bus decoder and the rx fifo
bind periph_bus msoc_props #(
  .BUS_CHECKS  (1'b1),
  .FIFO_CHECKS (1'b0)
) u_bus_props (
  .msoc_clk (msoc_clk),
  .rstn     (rstn),
  .req_i    (bus_req_i.req),
  .gnt_i    (gnt_o),
  .rvalid_i (rvalid_o),
  .full_i   (1'b0),
  .empty_i  (1'b0)
);

bind rx_fifo msoc_props #(
  .BUS_CHECKS  (1'b0),
  .FIFO_CHECKS (1'b1)
) u_fifo_props (
  .msoc_clk (msoc_clk),
  .rstn     (rstn),
  .req_i    (1'b0),
  .gnt_i    (1'b0),
  .rvalid_i (1'b0),
  .full_i   (full_o),
  .empty_i  (empty_o)
);

`default_nettype wire

// ==== verilog/msoc_periph_top.sv ====
// peripheral subsystem top: bus decoder, data ram and uart
`timescale 1ns/1ps
`default_nettype none

module msoc_periph_top #(
  parameter int              RAM_AW     = 10,
  parameter int              FIFO_DEPTH = 16,
  parameter msoc_pkg::baud_t BAUD_INIT  = msoc_pkg::BAUD_RESET
)
(
  input  wire                     msoc_clk,
  input  wire                     rstn,
  input  wire msoc_pkg::bus_req_t bus_req_i,
  output logic                    gnt_o,
  output logic                    rvalid_o,
  output msoc_pkg::word_t         rdata_o,
  output msoc_pkg::led_t          led_o,
  input  wire msoc_pkg::dip_t     dip_i,
  input  wire                     uart_rx_i,
  output logic                    uart_tx_o
);
  import msoc_pkg::*;

  logic  ram_we;
  logic  uart_ctrl_we;
  logic  uart_pop;
  word_t ram_rdata;
  word_t uart_rdata;

  periph_bus u_bus (
    .msoc_clk       (msoc_clk),
    .rstn           (rstn),
    .bus_req_i      (bus_req_i),
    .gnt_o          (gnt_o),
    .rvalid_o       (rvalid_o),
    .rdata_o        (rdata_o),
    .ram_we_o       (ram_we),
    .uart_ctrl_we_o (uart_ctrl_we),
    .uart_pop_o     (uart_pop),
    .ram_rdata_i    (ram_rdata),
    .uart_rdata_i   (uart_rdata),
    .led_o          (led_o),
    .dip_i          (dip_i)
  );

  data_ram #(
    .RAM_AW (RAM_AW)
  ) u_ram (
    .msoc_clk (msoc_clk),
    .req_i    (bus_req_i),
    .we_i     (ram_we),
    .rdata_o  (ram_rdata)
  );

  uart_periph #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .BAUD_INIT  (BAUD_INIT)
  ) u_uart (
    .msoc_clk  (msoc_clk),
    .rstn      (rstn),
    .req_i     (bus_req_i),
    .ctrl_we_i (uart_ctrl_we),
    .pop_i     (uart_pop),
    .rdata_o   (uart_rdata),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o)
  );

endmodule

`default_nettype wire

// ==== verilog/periph_bus.sv ====
// peripheral bus: slot decode, grant/valid timing, led and dip registers, read mux
`timescale 1ns/1ps
`default_nettype none

module periph_bus
(
  input  wire                 msoc_clk,
  input  wire                 rstn,
  input  wire msoc_pkg::bus_req_t bus_req_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  output msoc_pkg::word_t     rdata_o,
  output logic                ram_we_o,
  output logic                uart_ctrl_we_o,
  output logic                uart_pop_o,
  input  wire msoc_pkg::word_t ram_rdata_i,
  input  wire msoc_pkg::word_t uart_rdata_i,
  output msoc_pkg::led_t      led_o,
  input  wire msoc_pkg::dip_t dip_i
);
  import msoc_pkg::*;

  slot_t slot;
  slot_t slot_q;     // slot of the request being answered
  logic  bus_wr;
  led_t  led_q;
  dip_t  dip_q;

  assign slot   = bus_req_i.addr[SLOT_MSB:SLOT_LSB];
  assign bus_wr = bus_req_i.req & bus_req_i.we;
  assign gnt_o  = bus_req_i.req;   // never any back-pressure

  assign ram_we_o       = bus_wr && (slot == SLOT_RAM);
  assign uart_ctrl_we_o = bus_wr && (slot == SLOT_UART_CTRL);
  assign uart_pop_o     = bus_wr && (slot == SLOT_UART_RX);
  assign led_o          = led_q;

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rvalid_o <= 1'b0;
      slot_q   <= '0;
      led_q    <= '0;
    end
    else
    begin
      rvalid_o <= bus_req_i.req;   // one cycle after grant
      if (bus_req_i.req)
        slot_q <= slot;
      if (bus_wr && (slot == SLOT_GPIO))
        led_q <= led_t'(bus_req_i.wdata);
    end
  end

  always_ff @(posedge msoc_clk)
    dip_q <= dip_i;   // switches sampled every cycle

  ////////////////////////////////////////////////////////////
  // response word
  always_comb
  begin
    case (slot_q)
      SLOT_RAM:       rdata_o = ram_rdata_i;
      SLOT_UART_CTRL,
      SLOT_UART_RX:   rdata_o = uart_rdata_i;   // uart block picks baud or status
      SLOT_GPIO:      rdata_o = word_t'(dip_q);
      default:        rdata_o = '0;             // unmapped
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/uart_periph.sv ====
// uart register block: tx strobe, baud register, status word, core and rx fifo
`timescale 1ns/1ps
`default_nettype none

module uart_periph #(
  parameter int              FIFO_DEPTH = 16,
  parameter msoc_pkg::baud_t BAUD_INIT  = msoc_pkg::BAUD_RESET
)
(
  input  wire                     msoc_clk,
  input  wire                     rstn,
  input  wire msoc_pkg::bus_req_t req_i,
  input  wire                     ctrl_we_i,
  input  wire                     pop_i,
  output msoc_pkg::word_t         rdata_o,
  input  wire                     uart_rx_i,
  output logic                    uart_tx_o
);
  import msoc_pkg::*;

  baud_t          baud_q;
  byte_t          tx_byte_q;
  logic           tx_start_q;
  logic           rx_sel_q;     // request was for slot 3
  logic           tx_wr;
  logic           baud_wr;
  logic           rx_valid;
  uart_rx_entry_t rx_entry;
  uart_rx_entry_t fifo_head;
  logic           fifo_empty;
  logic           fifo_full;
  logic           tx_busy;
  logic           rx_busy;
  uart_status_t   status;

  assign tx_wr   = ctrl_we_i && (req_i.addr[3:2] == UART_REG_TX);
  assign baud_wr = ctrl_we_i && (req_i.addr[3:2] == UART_REG_BAUD);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      baud_q     <= BAUD_INIT;
      tx_start_q <= 1'b0;
      rx_sel_q   <= 1'b0;
    end
    else
    begin
      tx_start_q <= tx_wr;   // single cycle pulse
      if (baud_wr)
        baud_q <= baud_t'(req_i.wdata);
      if (req_i.req)
        rx_sel_q <= req_i.addr[SLOT_LSB];   // slots 2 and 3 differ only here
    end
  end

  always_ff @(posedge msoc_clk)
    if (tx_wr)
      tx_byte_q <= byte_t'(req_i.wdata);

  always_comb
  begin
    status              = '0;
    status.data         = fifo_head.data;
    status.err          = fifo_head.err;
    status.not_empty    = ~fifo_empty;
    status.receiving    = rx_busy;
    status.transmitting = tx_busy;
    status.full         = fifo_full;
  end

  assign rdata_o = rx_sel_q ? word_t'(status) : word_t'(baud_q);

  uart_core u_core (
    .msoc_clk   (msoc_clk),
    .rstn       (rstn),
    .baud_i     (baud_q),
    .tx_start_i (tx_start_q),
    .tx_byte_i  (tx_byte_q),
    .rx_i       (uart_rx_i),
    .tx_o       (uart_tx_o),
    .rx_valid_o (rx_valid),
    .rx_entry_o (rx_entry),
    .tx_busy_o  (tx_busy),
    .rx_busy_o  (rx_busy)
  );

  rx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_rx_fifo (
    .msoc_clk (msoc_clk),
    .rstn     (rstn),
    .push_i   (rx_valid),
    .din_i    (rx_entry),
    .pop_i    (pop_i),
    .dout_o   (fifo_head),
    .empty_o  (fifo_empty),
    .full_o   (fifo_full)
  );

endmodule

`default_nettype wire

// ==== verilog/rx_fifo.sv ====
// first-word-fall-through fifo for received uart entries
`timescale 1ns/1ps
`default_nettype none

module rx_fifo #(
  parameter int FIFO_DEPTH = 16
)
(
  input  wire                            msoc_clk,
  input  wire                            rstn,
  input  wire                            push_i,
  input  wire msoc_pkg::uart_rx_entry_t  din_i,
  input  wire                            pop_i,
  output msoc_pkg::uart_rx_entry_t       dout_o,
  output logic                           empty_o,
  output logic                           full_o
);
  import msoc_pkg::*;

  localparam int            AW        = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [AW-1:0] LAST_PTR  = AW'(FIFO_DEPTH - 1);
  localparam logic [AW:0]   DEPTH_CNT = (AW+1)'(FIFO_DEPTH);

  uart_rx_entry_t mem [FIFO_DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic [AW:0]    count;      // occupancy
  logic           do_push;
  logic           do_pop;

  assign empty_o = (count == '0);
  assign full_o  = (count == DEPTH_CNT);
  assign do_push = push_i & ~full_o;    // overflow dropped
  assign do_pop  = pop_i & ~empty_o;
  assign dout_o  = mem[rd_ptr];         // head always visible

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      count <= count + do_push - do_pop;
    end
  end

  always_ff @(posedge msoc_clk)
    if (do_push)
      mem[wr_ptr] <= din_i;

endmodule

`default_nettype wire

// ==== verilog/uart_core.sv ====
// uart core: rx majority filter, 8n1 transmitter and receiver, programmable bit period
`timescale 1ns/1ps
`default_nettype none

module uart_core
(
  input  wire                      msoc_clk,
  input  wire                      rstn,
  input  wire msoc_pkg::baud_t     baud_i,
  input  wire                      tx_start_i,
  input  wire msoc_pkg::byte_t     tx_byte_i,
  input  wire                      rx_i,
  output logic                     tx_o,
  output logic                     rx_valid_o,
  output msoc_pkg::uart_rx_entry_t rx_entry_o,
  output logic                     tx_busy_o,
  output logic                     rx_busy_o
);
  import msoc_pkg::*;

  logic [2:0]     rx_samp;
  logic           rx_f;       // filtered line
  logic           rx_prev;
  baud_t          baud_m1;
  baud_t          half_m1;
  uart_tx_state_t tx_state;
  baud_t          tx_cnt;
  logic [2:0]     tx_bit;
  byte_t          tx_shift;
  uart_rx_state_t rx_state;
  baud_t          rx_cnt;
  logic [2:0]     rx_bit;
  byte_t          rx_shift;

  assign baud_m1   = baud_i - 1'b1;
  assign half_m1   = (baud_i >> 1) - 1'b1;
  assign rx_f      = (rx_samp[0] & rx_samp[1]) | (rx_samp[1] & rx_samp[2]) |
                     (rx_samp[0] & rx_samp[2]);
  assign tx_busy_o = (tx_state != TX_IDLE);
  assign rx_busy_o = (rx_state != RX_IDLE);

  ////////////////////////////////////////////////////////////
  // 2 of 3 vote, two cycles of latency
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rx_samp <= 3'b111;   // line idles high
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_samp <= {rx_samp[1:0], rx_i};
      rx_prev <= rx_f;
    end
  end

  ////////////////////////////////////////////////////////////
  // transmitter
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      tx_state <= TX_IDLE;
      tx_cnt   <= '0;
      tx_bit   <= '0;
      tx_shift <= '0;
      tx_o     <= 1'b1;
    end
    else
    begin
      tx_cnt <= tx_cnt + 1'b1;
      unique case (tx_state)
        TX_IDLE:
          if (tx_start_i)   // only sampled here, busy strobes are lost
          begin
            tx_shift <= tx_byte_i;
            tx_cnt   <= '0;
            tx_o     <= 1'b0;
            tx_state <= TX_START;
          end
        TX_START:
          if (tx_cnt == baud_m1)
          begin
            tx_cnt   <= '0;
            tx_bit   <= '0;
            tx_o     <= tx_shift[0];   // lsb first
            tx_state <= TX_DATA;
          end
        TX_DATA:
          if (tx_cnt == baud_m1)
          begin
            tx_cnt   <= '0;
            tx_bit   <= tx_bit + 1'b1;
            tx_shift <= {1'b0, tx_shift[7:1]};
            tx_o     <= (tx_bit == 3'd7) ? 1'b1 : tx_shift[1];
            if (tx_bit == 3'd7)
              tx_state <= TX_STOP;
          end
        TX_STOP:
          if (tx_cnt == baud_m1)
            tx_state <= TX_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // receiver, samples mid-bit
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rx_state   <= RX_IDLE;
      rx_cnt     <= '0;
      rx_bit     <= '0;
      rx_shift   <= '0;
      rx_valid_o <= 1'b0;
      rx_entry_o <= '0;
    end
    else
    begin
      rx_valid_o <= 1'b0;
      rx_cnt     <= rx_cnt + 1'b1;
      unique case (rx_state)
        RX_IDLE:
          if (rx_prev && !rx_f)   // falling edge, a stuck-low line is ignored
          begin
            rx_cnt   <= '0;
            rx_state <= RX_START;
          end
        RX_START:
          if (rx_cnt == half_m1)
          begin
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_state <= rx_f ? RX_IDLE : RX_DATA;   // glitch rejected
          end
        RX_DATA:
          if (rx_cnt == baud_m1)
          begin
            rx_cnt   <= '0;
            rx_bit   <= rx_bit + 1'b1;
            rx_shift <= {rx_f, rx_shift[7:1]};
            if (rx_bit == 3'd7)
              rx_state <= RX_STOP;
          end
        RX_STOP:
          if (rx_cnt == baud_m1)
          begin
            rx_valid_o      <= 1'b1;
            rx_entry_o.err  <= !rx_f;   // framing error
            rx_entry_o.data <= rx_shift;
            rx_state        <= RX_IDLE;
          end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/data_ram.sv ====
// single-port data ram with byte lane writes and registered read
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
  parameter int RAM_AW = 10
)
(
  input  wire                     msoc_clk,
  input  wire msoc_pkg::bus_req_t req_i,
  input  wire                     we_i,
  output msoc_pkg::word_t         rdata_o
);
  import msoc_pkg::*;

  word_t             mem [2**RAM_AW];
  logic [RAM_AW-1:0] widx;

  assign widx = req_i.addr[RAM_AW+1:2];   // word address

  // read every edge, old data wins over a same-cycle write
  always_ff @(posedge msoc_clk)
  begin
    rdata_o <= mem[widx];
    if (we_i)
      for (int b = 0; b < 4; b++)
        if (req_i.be[b])
          mem[widx][8*b +: 8] <= req_i.wdata[8*b +: 8];
  end

endmodule

`default_nettype wire

// ==== verilog/msoc_pkg.sv ====
// shared widths, slot map, bus and uart structs, uart fsm state encodings
`default_nettype none

package msoc_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;   // byte address
  typedef logic [3:0]  be_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] led_t;
  typedef logic [7:0]  dip_t;
  typedef logic [10:0] baud_t;   // cycles per serial bit
  typedef logic [3:0]  slot_t;

  ////////////////////////////////////////////////////////////
  // address map
  localparam int    SLOT_MSB       = 23;
  localparam int    SLOT_LSB       = 20;
  localparam slot_t SLOT_RAM       = 4'd1;
  localparam slot_t SLOT_UART_CTRL = 4'd2;
  localparam slot_t SLOT_UART_RX   = 4'd3;   // write pops the rx fifo
  localparam slot_t SLOT_GPIO      = 4'd7;

  localparam logic [1:0] UART_REG_TX   = 2'd0;   // word offsets in slot 2
  localparam logic [1:0] UART_REG_BAUD = 2'd1;
  localparam baud_t      BAUD_RESET    = 11'd54;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
    be_t   be;
  } bus_req_t;

  typedef struct packed {
    logic  err;    // stop bit was zero
    byte_t data;
  } uart_rx_entry_t;

  typedef struct packed {
    logic [18:0] zero;
    logic        full;
    logic        transmitting;
    logic        receiving;
    logic        not_empty;
    logic        err;
    byte_t       data;   // fifo head
  } uart_status_t;

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_tx_state_t;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} uart_rx_state_t;

endpackage

`default_nettype wire
